//--- rtl/vfdsu_denorm_round.sv
`timescale 1ns/1ps

module vfdsu_denorm_round
  import vfdsu_pkg::*;
(
  input  logic [EXP_W-1:0]  expnt_rst,
  input  fp_fmt_e           fmt,
  output logic [RADD_W-1:0] denorm_add
);

  logic signed [EXP_W-1:0] rst_s;
  int                      min_norm;
  int                      base_bit;
  int                      below;
  int                      bit_pos;

  assign rst_s = expnt_rst;

  // Smallest normal exponent and its increment bit
  always_comb
  begin
    case (fmt)
      FMT_HALF:
      begin
        min_norm = POTNT_UF_H;
        base_bit = DENORM_BASE_H;
      end
      FMT_SINGLE:
      begin
        min_norm = POTNT_UF_S;
        base_bit = DENORM_BASE_S;
      end
      default:
      begin
        min_norm = POTNT_UF_D;
        base_bit = DENORM_BASE_D;
      end
    endcase
  end

  // ==============================
  // One-hot increment
  // ==============================
  // Each step below min normal shifts the round point up one bit
  assign below   = min_norm - rst_s;
  assign bit_pos = base_bit + below;

  assign denorm_add = (below >= 0 && bit_pos < RADD_W) ? (RADD_W'(1) << bit_pos)
                                                       : '0;

endmodule

//--- rtl/vfdsu_ex2_expnt.sv
`timescale 1ns/1ps

module vfdsu_ex2_expnt
  import vfdsu_pkg::*;
(
  input  logic      ex2_pipe_clk,
  input  logic      cpurst_b,
  input  logic      ex2_pipedown,
  input  ex2_op_t   ex2_op,
  output logic      skip_srt,
  output ex3_info_t ex3_info
);

  expnt_flags_t      flags;
  logic [RADD_W-1:0] denorm_add;

  // ==============================
  // EX2 exponent checks
  // ==============================
  vfdsu_expnt_check u_expnt_check (
    .ex2_op (ex2_op),
    .flags  (flags)
  );

  vfdsu_denorm_round u_denorm_round (
    .expnt_rst  (flags.expnt_rst),
    .fmt        (ex2_op.fmt),
    .denorm_add (denorm_add)
  );

  // ==============================
  // SRT skip
  // ==============================
  // Overflow, tiny result, or an earlier stage already resolved it
  assign skip_srt = flags.of || flags.id_nor_skip || ex2_op.id_srt_skip_in;

  // ==============================
  // Pipe to EX3
  // ==============================
  vfdsu_ex3_pipe u_ex3_pipe (
    .ex2_pipe_clk (ex2_pipe_clk),
    .cpurst_b     (cpurst_b),
    .ex2_pipedown (ex2_pipedown),
    .ex2_op       (ex2_op),
    .flags        (flags),
    .denorm_add   (denorm_add),
    .ex3_info     (ex3_info)
  );

endmodule

//--- rtl/vfdsu_ex3_pipe.sv
`timescale 1ns/1ps

module vfdsu_ex3_pipe
  import vfdsu_pkg::*;
(
  input  logic              ex2_pipe_clk,
  input  logic              cpurst_b,
  input  logic              ex2_pipedown,
  input  ex2_op_t           ex2_op,
  input  expnt_flags_t      flags,
  input  logic [RADD_W-1:0] denorm_add,
  output ex3_info_t         ex3_info
);

  ex3_info_t ex3_nxt;
  logic      result_inf;
  logic      result_lfn;

  // ==============================
  // Special result merge
  // ==============================
  // Overflow gives inf or largest finite, per rounding mode
  assign result_inf = ex2_op.in_inf || (flags.of && !ex2_op.of_rm_lfn);
  assign result_lfn = flags.of && ex2_op.of_rm_lfn;

  always_comb
  begin
    ex3_nxt.result_zero = ex2_op.in_zero;
    ex3_nxt.result_qnan = ex2_op.in_qnan;
    ex3_nxt.result_inf  = result_inf;
    ex3_nxt.result_lfn  = result_lfn;
    ex3_nxt.of          = flags.of;
    ex3_nxt.uf          = flags.uf;
    ex3_nxt.nv          = ex2_op.nv;
    ex3_nxt.dz          = ex2_op.dz;
    ex3_nxt.potnt_of    = flags.potnt_of;
    ex3_nxt.potnt_uf    = flags.potnt_uf;
    ex3_nxt.expnt_rst   = flags.expnt_rst;
    ex3_nxt.result_sign = ex2_op.result_sign;
    ex3_nxt.qnan_sign   = ex2_op.qnan_sign;
    ex3_nxt.qnan_f      = ex2_op.qnan_f;
    ex3_nxt.rm          = ex2_op.rm;
    ex3_nxt.denorm_add  = denorm_add;
    // Underflowed quotient is produced as a denormal
    ex3_nxt.rslt_denorm = flags.uf;
    ex3_nxt.id_srt_skip = flags.id_nor_skip;
    ex3_nxt.fmt         = ex2_op.fmt;
  end

  // ==============================
  // EX3 register
  // ==============================
  always_ff @(posedge ex2_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex3_info <= '0;
    end
    else if (ex2_pipedown)
    begin
      ex3_info <= ex3_nxt;
    end
  end

  // Input inf never coexists with a normal-operand overflow
  assert property (@(posedge ex2_pipe_clk) disable iff (!cpurst_b)
                   !(ex3_info.result_inf && ex3_info.result_lfn))
    else $error("vfdsu_ex3_pipe: result_inf and result_lfn both set");

endmodule

//--- rtl/vfdsu_expnt_check.sv
`timescale 1ns/1ps

module vfdsu_expnt_check
  import vfdsu_pkg::*;
(
  input  ex2_op_t      ex2_op,
  output expnt_flags_t flags
);

  logic [EXP_W-1:0]        expnt_diff;
  logic [EXP_W-1:0]        expnt_rst;
  logic signed [EXP_W-1:0] rst_full;
  logic signed [EXP_W-1:0] rst_fmt;
  int                      of_above;
  int                      potnt_of_at;
  int                      uf_at;
  int                      potnt_uf_at;
  int                      skip_below;
  logic                    is_div;
  logic                    both_norm;
  logic                    expnt_of;
  logic                    expnt_uf;
  logic                    potnt_of_pre;
  logic                    potnt_uf_pre;

  // ==============================
  // Exponent difference
  // ==============================
  assign expnt_diff = ex2_op.expnt_add0 - ex2_op.expnt_add1;

  // Square root halves it, arithmetic shift
  assign expnt_rst = (ex2_op.op == OP_SQRT) ? {expnt_diff[EXP_W-1], expnt_diff[EXP_W-1:1]}
                                            : expnt_diff;
  assign rst_full  = expnt_rst;

  // ==============================
  // Per-format view and bounds
  // ==============================
  // Overflow and the potential checks read the sign at the format's width
  always_comb
  begin
    case (ex2_op.fmt)
      FMT_HALF:
      begin
        rst_fmt     = {{(EXP_W-7){expnt_rst[6]}}, expnt_rst[6:0]};
        of_above    = OF_ABOVE_H;
        potnt_of_at = POTNT_OF_H;
        uf_at       = UF_AT_H;
        potnt_uf_at = POTNT_UF_H;
        skip_below  = SKIP_BELOW_H;
      end
      FMT_SINGLE:
      begin
        rst_fmt     = {{(EXP_W-10){expnt_rst[9]}}, expnt_rst[9:0]};
        of_above    = OF_ABOVE_S;
        potnt_of_at = POTNT_OF_S;
        uf_at       = UF_AT_S;
        potnt_uf_at = POTNT_UF_S;
        skip_below  = SKIP_BELOW_S;
      end
      default:
      begin
        rst_fmt     = rst_full;
        of_above    = OF_ABOVE_D;
        potnt_of_at = POTNT_OF_D;
        uf_at       = UF_AT_D;
        potnt_uf_at = POTNT_UF_D;
        skip_below  = SKIP_BELOW_D;
      end
    endcase
  end

  assign expnt_of     = rst_fmt > of_above;
  assign potnt_of_pre = rst_fmt == potnt_of_at;
  assign potnt_uf_pre = rst_fmt == potnt_uf_at;

  // Underflow and skip use the full 13-bit value
  assign expnt_uf     = rst_full <= uf_at;

  // ==============================
  // Qualified flags
  // ==============================
  assign is_div    = (ex2_op.op == OP_DIV);
  assign both_norm = ex2_op.op0_norm && ex2_op.op1_norm;

  assign flags.expnt_rst   = expnt_rst;
  assign flags.of          = expnt_of && both_norm && is_div;
  assign flags.uf          = expnt_uf && both_norm && is_div;
  assign flags.potnt_of    = potnt_of_pre && both_norm && is_div;
  // Square root has a single operand
  assign flags.potnt_uf    = potnt_uf_pre && ex2_op.op0_norm
                             && (ex2_op.op1_norm || !is_div);
  assign flags.id_nor_skip = rst_full < skip_below;

  // Encoding 2'b11 would silently take the double bounds
  always_comb
  begin
    assert ($isunknown(ex2_op.fmt) || ex2_op.fmt != 2'b11)
      else $error("vfdsu_expnt_check: unused fmt encoding %b", ex2_op.fmt);
  end

endmodule

//--- rtl/vfdsu_pkg.sv
package vfdsu_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int EXP_W  = 13;
  localparam int FRAC_W = 52;
  localparam int RADD_W = 53;

  typedef enum logic [1:0] {
    FMT_HALF   = 2'b00,
    FMT_SINGLE = 2'b01,
    FMT_DOUBLE = 2'b10
  } fp_fmt_e;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } fp_op_e;

  // Rounding mode, not decoded in EX2
  typedef logic [2:0] rm_t;

  // ==============================
  // Exponent bounds per format
  // ==============================
  // Overflow when the difference is above this
  localparam int OF_ABOVE_H    = 16;
  localparam int OF_ABOVE_S    = 128;
  localparam int OF_ABOVE_D    = 1024;
  // Potential overflow, exact match
  localparam int POTNT_OF_H    = 16;
  localparam int POTNT_OF_S    = 128;
  localparam int POTNT_OF_D    = 1024;
  // Underflow at or below
  localparam int UF_AT_H       = -15;
  localparam int UF_AT_S       = -127;
  localparam int UF_AT_D       = -1023;
  // Potential underflow, also the smallest normal exponent
  localparam int POTNT_UF_H    = -14;
  localparam int POTNT_UF_S    = -126;
  localparam int POTNT_UF_D    = -1022;
  // SRT is skipped below this, the result rounds to zero or min denormal
  localparam int SKIP_BELOW_H  = -25;
  localparam int SKIP_BELOW_S  = -150;
  localparam int SKIP_BELOW_D  = -1075;
  // Bit of the rounding increment at the smallest normal exponent
  localparam int DENORM_BASE_H = 42;
  localparam int DENORM_BASE_S = 29;
  localparam int DENORM_BASE_D = 0;

  // ==============================
  // Stage bundles
  // ==============================
  typedef struct packed {
    fp_op_e             op;
    fp_fmt_e            fmt;
    logic [EXP_W-1:0]   expnt_add0;
    logic [EXP_W-1:0]   expnt_add1;
    logic               op0_norm;
    logic               op1_norm;
    rm_t                rm;
    logic               result_sign;
    logic               qnan_sign;
    logic [FRAC_W-1:0]  qnan_f;
    logic               in_zero;
    logic               in_qnan;
    logic               in_inf;
    logic               nv;
    logic               dz;
    logic               of_rm_lfn;
    logic               id_srt_skip_in;
  } ex2_op_t;

  typedef struct packed {
    logic [EXP_W-1:0]   expnt_rst;
    logic               of;
    logic               uf;
    logic               potnt_of;
    logic               potnt_uf;
    logic               id_nor_skip;
  } expnt_flags_t;

  typedef struct packed {
    logic               result_zero;
    logic               result_qnan;
    logic               result_inf;
    logic               result_lfn;
    logic               of;
    logic               uf;
    logic               nv;
    logic               dz;
    logic               potnt_of;
    logic               potnt_uf;
    logic [EXP_W-1:0]   expnt_rst;
    logic               result_sign;
    logic               qnan_sign;
    logic [FRAC_W-1:0]  qnan_f;
    rm_t                rm;
    logic [RADD_W-1:0]  denorm_add;
    logic               rslt_denorm;
    logic               id_srt_skip;
    fp_fmt_e            fmt;
  } ex3_info_t;

endpackage

//--- run.sh
#!/bin/sh
# Verilator build and run of the EX2 exponent stage testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vfdsu_ex2 -f src.f -Mdir obj_dir -o tb_vfdsu_ex2
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_vfdsu_ex2 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "Simulation ended without a result line, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- src.f
rtl/vfdsu_pkg.sv
rtl/vfdsu_expnt_check.sv
rtl/vfdsu_denorm_round.sv
rtl/vfdsu_ex3_pipe.sv
rtl/vfdsu_ex2_expnt.sv
verif/tb_vfdsu_ex2.sv

//--- verif/tb_vfdsu_ex2.sv
`timescale 1ns/1ps

module tb_vfdsu_ex2
  import vfdsu_pkg::*;
();

  logic      ex2_pipe_clk;
  logic      cpurst_b;
  logic      ex2_pipedown;
  ex2_op_t   ex2_op;
  logic      skip_srt;
  ex3_info_t ex3_info;

  // Vectors from the golden file
  string     vec_name[$];
  ex2_op_t   vec_op[$];
  logic      vec_pd[$];
  logic      vec_skip[$];
  ex3_info_t vec_exp[$];

  ex3_info_t held_exp;
  string     cur_test;
  integer    seed;
  integer    fd;
  int        cycle_cnt;
  int        cycle_limit;
  logic      load_done;
  int        test_errors;
  int        error_total;
  int        check_total;
  int        test_total;
  int        test_failed;

  vfdsu_ex2_expnt u_vfdsu_ex2_expnt (
    .ex2_pipe_clk (ex2_pipe_clk),
    .cpurst_b     (cpurst_b),
    .ex2_pipedown (ex2_pipedown),
    .ex2_op       (ex2_op),
    .skip_srt     (skip_srt),
    .ex3_info     (ex3_info)
  );

  initial
  begin
    ex2_pipe_clk = 1'b0;
    forever #4 ex2_pipe_clk = ~ex2_pipe_clk;
  end

  // ==============================
  // Checking helpers
  // ==============================
  task automatic check_field(input string field, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    check_total++;
    assert (act_v === exp_v)
    else
    begin
      $display("** Error %s %s: expected %0h, actual %0h", cur_test, field, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic compare_ex3(input ex3_info_t e);
    check_field("result_zero", e.result_zero, ex3_info.result_zero);
    check_field("result_qnan", e.result_qnan, ex3_info.result_qnan);
    check_field("result_inf", e.result_inf, ex3_info.result_inf);
    check_field("result_lfn", e.result_lfn, ex3_info.result_lfn);
    check_field("of", e.of, ex3_info.of);
    check_field("uf", e.uf, ex3_info.uf);
    check_field("nv", e.nv, ex3_info.nv);
    check_field("dz", e.dz, ex3_info.dz);
    check_field("potnt_of", e.potnt_of, ex3_info.potnt_of);
    check_field("potnt_uf", e.potnt_uf, ex3_info.potnt_uf);
    check_field("expnt_rst", e.expnt_rst, ex3_info.expnt_rst);
    check_field("result_sign", e.result_sign, ex3_info.result_sign);
    check_field("qnan_sign", e.qnan_sign, ex3_info.qnan_sign);
    check_field("qnan_f", e.qnan_f, ex3_info.qnan_f);
    check_field("rm", e.rm, ex3_info.rm);
    check_field("denorm_add", e.denorm_add, ex3_info.denorm_add);
    check_field("rslt_denorm", e.rslt_denorm, ex3_info.rslt_denorm);
    check_field("id_srt_skip", e.id_srt_skip, ex3_info.id_srt_skip);
    check_field("fmt", e.fmt, ex3_info.fmt);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    test_total++;
  endtask

  task automatic finish_test();
    if (test_errors == 0)
      $display("PASS %s", cur_test);
    else
    begin
      $display("FAIL %s with %0d errors", cur_test, test_errors);
      test_failed++;
    end
    error_total += test_errors;
  endtask

  // ==============================
  // Golden file
  // ==============================
  task automatic load_vectors();
    string            line;
    logic [8*16-1:0]  f_name;
    logic             f_op, f_n0, f_n1, f_lfn, f_skin, f_pd;
    logic             f_skip, f_of, f_uf, f_pof, f_puf, f_inf, f_rlfn, f_nskp;
    logic [1:0]       f_fmt;
    logic [2:0]       f_rm;
    logic [6:0]       f_spec;
    logic [12:0]      f_a0, f_a1, f_rst;
    logic [51:0]      f_qf;
    logic [52:0]      f_dadd;
    ex2_op_t          op;
    ex3_info_t        e;
    int               n;
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %b %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f_name, f_op, f_fmt, f_a0, f_a1, f_n0, f_n1, f_rm, f_spec, f_qf,
                  f_lfn, f_skin, f_pd, f_skip, f_rst, f_of, f_uf, f_pof, f_puf,
                  f_inf, f_rlfn, f_nskp, f_dadd);
      if (n != 23)
      begin
        $display("Malformed golden line, %0d fields read: %s", n, line);
        error_total++;
        continue;
      end
      op            = '0;
      op.op         = fp_op_e'(f_op);
      op.fmt        = fp_fmt_e'(f_fmt);
      op.expnt_add0 = f_a0;
      op.expnt_add1 = f_a1;
      op.op0_norm   = f_n0;
      op.op1_norm   = f_n1;
      op.rm         = f_rm;
      op.qnan_f     = f_qf;
      {op.result_sign, op.qnan_sign, op.in_zero, op.in_qnan, op.in_inf, op.nv, op.dz} = f_spec;
      op.of_rm_lfn      = f_lfn;
      op.id_srt_skip_in = f_skin;
      // Pass-through fields come straight from the stimulus
      e             = '0;
      e.result_zero = op.in_zero;
      e.result_qnan = op.in_qnan;
      e.result_inf  = f_inf;
      e.result_lfn  = f_rlfn;
      e.of          = f_of;
      e.uf          = f_uf;
      e.nv          = op.nv;
      e.dz          = op.dz;
      e.potnt_of    = f_pof;
      e.potnt_uf    = f_puf;
      e.expnt_rst   = f_rst;
      e.result_sign = op.result_sign;
      e.qnan_sign   = op.qnan_sign;
      e.qnan_f      = op.qnan_f;
      e.rm          = op.rm;
      e.denorm_add  = f_dadd;
      e.rslt_denorm = f_uf;
      e.id_srt_skip = f_nskp;
      e.fmt         = op.fmt;
      vec_name.push_back($sformatf("%0s", f_name));
      vec_op.push_back(op);
      vec_pd.push_back(f_pd);
      vec_skip.push_back(f_skip);
      vec_exp.push_back(e);
    end
  endtask

  // Idle cycle with random operation, EX3 must not load
  task automatic drive_random_idle();
    logic [95:0] rnd;
    rnd    = {$random(seed), $random(seed), $random(seed)};
    ex2_op = ex2_op_t'(rnd[$bits(ex2_op_t)-1:0]);
    if (ex2_op.fmt == 2'b11)
      ex2_op.fmt = FMT_DOUBLE;
    ex2_pipedown = 1'b0;
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin : main_seq
    int idle_n;
    cpurst_b     = 1'b0;
    ex2_pipedown = 1'b0;
    ex2_op       = '0;
    held_exp     = '0;
    load_done    = 1'b0;
    error_total  = 0;
    check_total  = 0;
    test_total   = 0;
    test_failed  = 0;
    seed         = 32'h93508ca0;
    fd = $fopen("verif/vfdsu_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the golden file verif/vfdsu_golden.txt");
      $display("CHECKS FAILED");
      $finish;
    end
    else
    begin
      load_vectors();
      $fclose(fd);
      if (vec_op.size() == 0)
      begin
        $display("The golden file holds no vectors");
        error_total++;
      end
      cycle_limit = 40 * vec_op.size() + 100;
      load_done   = 1'b1;

      repeat (16) @(posedge ex2_pipe_clk);
      #1;
      cpurst_b = 1'b1;

      // One edge with pipedown low, register still clear
      start_test("reset");
      @(posedge ex2_pipe_clk);
      #1;
      compare_ex3('0);
      finish_test();

      foreach (vec_op[i])
      begin
        start_test(vec_name[i]);
        ex2_op       = vec_op[i];
        ex2_pipedown = vec_pd[i];
        @(negedge ex2_pipe_clk);
        check_field("skip_srt", vec_skip[i], skip_srt);
        @(posedge ex2_pipe_clk);
        #1;
        if (vec_pd[i])
          held_exp = vec_exp[i];
        compare_ex3(held_exp);
        idle_n = $unsigned($random(seed)) % 3;
        repeat (idle_n)
        begin
          drive_random_idle();
          @(posedge ex2_pipe_clk);
          #1;
          compare_ex3(held_exp);
        end
        finish_test();
      end

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               test_total, test_failed, check_total, error_total);
      if (error_total == 0)
        $display("ALL CHECKS PASSED");
      else
        $display("CHECKS FAILED");
      $finish;
    end
  end

  // Cycle limit from the number of vectors
  initial
  begin : watchdog
    cycle_cnt = 0;
    wait (load_done);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge ex2_pipe_clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- verif/vfdsu_golden.txt
# name op fmt add0 add1 n0 n1 rm spec qnan_f lfn skin pd skip rst of uf pof puf inf lfn nskp dadd
# spec bits: result_sign qnan_sign in_zero in_qnan in_inf nv dz; spec binary, the rest hex
h_of      0 0 0020 000f 1 1 0 0000000 0 0 0 1  1 0011 1 0 0 0 1 0 0 0
h_pof     0 0 0010 0000 1 1 0 0000000 0 0 0 1  0 0010 0 0 1 0 0 0 0 0
h_uf      0 0 1ff1 0000 1 1 0 0000000 0 0 0 1  0 1ff1 0 1 0 0 0 0 0 80000000000
h_puf     0 0 1ff2 0000 1 1 0 0000000 0 0 0 1  0 1ff2 0 0 0 1 0 0 0 40000000000
h_dn52    0 0 1fe8 0000 1 1 0 0000000 0 0 0 1  0 1fe8 0 1 0 0 0 0 0 10000000000000
h_dn53    0 0 1fe7 0000 1 1 0 0000000 0 0 0 1  0 1fe7 0 1 0 0 0 0 0 0
h_skip    0 0 1fe6 0000 1 1 0 0000000 0 0 0 1  1 1fe6 0 1 0 0 0 0 1 0
h_of_n0   0 0 0011 0000 0 1 0 0000000 0 0 0 1  0 0011 0 0 0 0 0 0 0 0
h_puf_sq  1 0 1fe4 0000 1 0 0 0000000 0 0 0 1  0 1ff2 0 0 0 1 0 0 0 40000000000
s_of_lfn  0 1 0100 007f 1 1 0 0000000 0 1 0 1  1 0081 1 0 0 0 0 1 0 0
s_pof     0 1 0080 0000 1 1 0 0000000 0 0 0 1  0 0080 0 0 1 0 0 0 0 0
s_uf      0 1 1f81 0000 1 1 0 0000000 0 0 0 1  0 1f81 0 1 0 0 0 0 0 40000000
s_puf     0 1 1f82 0000 1 1 0 0000000 0 0 0 1  0 1f82 0 0 0 1 0 0 0 20000000
s_dn52    0 1 1f6b 0000 1 1 0 0000000 0 0 0 1  0 1f6b 0 1 0 0 0 0 0 10000000000000
s_dn53    0 1 1f6a 0000 1 1 0 0000000 0 0 0 1  0 1f6a 0 1 0 0 0 0 0 0
s_skip    0 1 1f69 0000 1 1 0 0000000 0 0 0 1  1 1f69 0 1 0 0 0 0 1 0
s_uf_n1   0 1 1f81 0000 1 0 0 0000000 0 0 0 1  0 1f81 0 0 0 0 0 0 0 40000000
d_of      0 2 07ff 03fe 1 1 0 0000000 0 0 0 1  1 0401 1 0 0 0 1 0 0 0
d_pof     0 2 0400 0000 1 1 0 0000000 0 0 0 1  0 0400 0 0 1 0 0 0 0 0
d_uf      0 2 0001 0400 1 1 0 0000000 0 0 0 1  0 1c01 0 1 0 0 0 0 0 2
d_puf     0 2 0000 03fe 1 1 0 0000000 0 0 0 1  0 1c02 0 0 0 1 0 0 0 1
d_dn52    0 2 1bce 0000 1 1 0 0000000 0 0 0 1  0 1bce 0 1 0 0 0 0 0 10000000000000
d_dn53    0 2 1bcd 0000 1 1 0 0000000 0 0 0 1  0 1bcd 0 1 0 0 0 0 0 0
d_skip    0 2 1bcc 0000 1 1 0 0000000 0 0 0 1  1 1bcc 0 1 0 0 0 0 1 0
sq_odd    1 2 0000 0009 1 1 0 0000000 0 0 0 1  0 1ffb 0 0 0 0 0 0 0 0
sq_big    1 2 0803 0000 1 1 0 0000000 0 0 0 1  0 0401 0 0 0 0 0 0 0 0
sq_neg    1 2 17cc 0000 1 1 0 0000000 0 0 0 1  0 1be6 0 0 0 0 0 0 0 10000000
sp_inf    0 2 0005 0003 1 1 3 1000100 0 0 0 1  0 0002 0 0 0 0 1 0 0 0
sp_pass   0 1 0123 0123 1 1 4 0111011 8000000000001 0 0 1  0 0000 0 0 0 0 0 0 0 0
sk_in     0 1 0005 0000 1 1 2 0000000 0 0 1 1  1 0005 0 0 0 0 0 0 0 0
hold_a    0 0 0020 000f 1 1 0 0000100 0 0 0 0  1 0011 1 0 0 0 1 0 0 0
hold_b    0 2 1bcc 0000 1 1 0 0000000 0 0 0 0  1 1bcc 0 1 0 0 0 0 1 0
reload    0 1 1f82 0000 1 1 1 0100000 0 0 0 1  0 1f82 0 0 0 1 0 0 0 20000000
